// File: common/lm_axi_pkg.sv
/*
 * Accelerator-side definitions for the local memory bridge.
 * Covers the line geometry, the credit limits and the request and
 * response words that cross the accelerator port.
 */
package lm_axi_pkg;

    // ====================
    // Line geometry
    // ====================
    localparam int LM_ADDR_W    = 26;
    localparam int LM_DATA_W    = 64;
    localparam int LM_BE_W      = LM_DATA_W / 8;
    localparam int LM_ID_W      = 4;
    localparam int LM_LEN_W     = 4;
    localparam int LM_MAX_LINES = 1 << LM_LEN_W;

    // Line count of one request, 1 to LM_MAX_LINES
    localparam int LM_CNT_W = LM_LEN_W + 1;

    // ====================
    // Credit limits
    // ====================
    // Outstanding line limits, which also size the internal FIFOs
    localparam int LM_RD_CREDITS = 32;
    localparam int LM_WR_CREDITS = 32;
    localparam int LM_RD_AW      = $clog2(LM_RD_CREDITS);
    localparam int LM_WR_AW      = $clog2(LM_WR_CREDITS);
    // Free credit counters must hold the full limit
    localparam int LM_CRED_W     = LM_RD_AW + 1;

    // Burst request, len holds the line count minus one
    typedef struct packed {
        logic                 is_write;
        logic [LM_ID_W-1:0]   id;
        logic [LM_ADDR_W-1:0] addr;
        logic [LM_LEN_W-1:0]  len;
    } lm_req_t;

    // One write line with its byte enables
    typedef struct packed {
        logic [LM_DATA_W-1:0] data;
        logic [LM_BE_W-1:0]   be;
    } lm_wdata_t;

    // One read response line
    typedef struct packed {
        logic [LM_ID_W-1:0]   id;
        logic [LM_DATA_W-1:0] data;
        logic                 last;
    } lm_rsp_t;

    // One response per write request
    typedef struct packed {
        logic [LM_ID_W-1:0] id;
    } lm_bresp_t;

endpackage

// File: common/lm_avmm_pkg.sv
/*
 * Avalon-side definitions for the local memory bridge.
 * Holds the burst limits, the split command chunk and the read tag.
 */
package lm_avmm_pkg;

    import lm_axi_pkg::*;

    // Memory accepts bursts of at most four lines
    localparam int AVMM_BURST_W   = 3;
    localparam int AVMM_MAX_BURST = 4;

    // Every outstanding line may sit in the command FIFO as its own chunk
    localparam int AVMM_CMD_DEPTH = LM_RD_CREDITS + LM_WR_CREDITS;
    localparam int AVMM_CMD_AW    = $clog2(AVMM_CMD_DEPTH);

    // One Avalon-sized piece of a request
    typedef struct packed {
        logic                    is_write;
        logic [LM_ADDR_W-1:0]    addr;
        logic [AVMM_BURST_W-1:0] burstcount;
        logic [LM_ID_W-1:0]      id;
        // Final chunk of its request
        logic                    last;
    } avmm_cmd_t;

    // Metadata kept for each issued read until its beats return
    typedef struct packed {
        logic [LM_ID_W-1:0]      id;
        logic [AVMM_BURST_W-1:0] lines;
        logic                    last;
    } avmm_tag_t;

endpackage

// File: hw/burst_map/lm_burst_mapper.sv
/*
 * Burst mapper.
 * Queues accelerator requests and cuts each one into Avalon command
 * chunks of at most AVMM_MAX_BURST lines, one chunk per cycle.
 */
`timescale 1ns/1ps

module lm_burst_mapper
    import lm_axi_pkg::*;
    import lm_avmm_pkg::*;
(
    input  logic      axi_afu_if,
    input  logic      arst_n,
    input  logic      req_valid,
    input  lm_req_t   req,
    output logic      cmd_valid,
    output avmm_cmd_t cmd
);

    // ====================
    // Request FIFO
    // ====================
    lm_req_t             rq_mem [LM_RD_CREDITS];
    logic [LM_RD_AW:0]   rq_wr_ptr;
    logic [LM_RD_AW:0]   rq_rd_ptr;
    logic                rq_empty;
    logic                rq_pop;
    lm_req_t             rq_head;

    // Splitter state for a request that still has lines left
    logic                    split_active;
    logic                    split_write;
    logic [LM_ID_W-1:0]      split_id;
    logic [LM_ADDR_W-1:0]    split_addr;
    logic [LM_CNT_W-1:0]     split_left;

    // Source of the chunk emitted this cycle
    logic                    src_write;
    logic [LM_ID_W-1:0]      src_id;
    logic [LM_ADDR_W-1:0]    src_addr;
    logic [LM_CNT_W-1:0]     src_left;
    logic [AVMM_BURST_W-1:0] chunk;
    logic [LM_CNT_W-1:0]     next_left;

    assign rq_empty = (rq_wr_ptr == rq_rd_ptr);
    assign rq_head  = rq_mem[rq_rd_ptr[LM_RD_AW-1:0]];

    always_ff @(posedge axi_afu_if)
    begin
        if (req_valid)
            rq_mem[rq_wr_ptr[LM_RD_AW-1:0]] <= req;
    end

    // ====================
    // Splitter
    // ====================
    // An idle splitter takes the FIFO head directly so the first chunk
    // leaves one cycle after the request strobe
    assign src_write = split_active ? split_write : rq_head.is_write;
    assign src_id    = split_active ? split_id    : rq_head.id;
    assign src_addr  = split_active ? split_addr  : rq_head.addr;
    assign src_left  = split_active ? split_left  : LM_CNT_W'(rq_head.len) + 1'b1;

    // Chunk is the smaller of the burst limit and the remaining lines
    assign chunk = (src_left > LM_CNT_W'(AVMM_MAX_BURST)) ?
                   AVMM_BURST_W'(AVMM_MAX_BURST) : src_left[AVMM_BURST_W-1:0];
    assign next_left = src_left - LM_CNT_W'(chunk);

    assign cmd_valid = split_active | ~rq_empty;
    assign rq_pop    = ~split_active & ~rq_empty;

    assign cmd.is_write   = src_write;
    assign cmd.addr       = src_addr;
    assign cmd.burstcount = chunk;
    assign cmd.id         = src_id;
    assign cmd.last       = (next_left == '0);

    always_ff @(posedge axi_afu_if or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rq_wr_ptr    <= '0;
            rq_rd_ptr    <= '0;
            split_active <= 1'b0;
        end
        else
        begin
            if (req_valid)
                rq_wr_ptr <= rq_wr_ptr + 1'b1;
            if (rq_pop)
                rq_rd_ptr <= rq_rd_ptr + 1'b1;
            // Stay busy while the current request has lines left
            if (cmd_valid)
                split_active <= (next_left != '0);
        end
    end

    // Residue of the request being split
    always_ff @(posedge axi_afu_if)
    begin
        if (cmd_valid)
        begin
            split_write <= src_write;
            split_id    <= src_id;
            split_addr  <= src_addr + LM_ADDR_W'(chunk);
            split_left  <= next_left;
        end
    end

endmodule

// File: hw/rsp_credits/lm_rsp_credits.sv
/*
 * Response credit tracker.
 * Counts free read and write line credits and raises a ready level
 * only when a full-size request can be absorbed.
 */
`timescale 1ns/1ps

module lm_rsp_credits
    import lm_axi_pkg::*;
(
    input  logic                axi_afu_if,
    input  logic                arst_n,
    input  logic                take_valid,
    input  logic                take_write,
    input  logic [LM_CNT_W-1:0] take_lines,
    input  logic                rd_line_done,
    input  logic                wr_line_done,
    output logic                rd_ready,
    output logic                wr_ready
);

    logic [LM_CRED_W-1:0] rd_free;
    logic [LM_CRED_W-1:0] wr_free;
    logic [LM_CRED_W-1:0] rd_take;
    logic [LM_CRED_W-1:0] wr_take;

    // Lines claimed this cycle by each kind of request
    assign rd_take = (take_valid && !take_write) ? LM_CRED_W'(take_lines) : '0;
    assign wr_take = (take_valid &&  take_write) ? LM_CRED_W'(take_lines) : '0;

    always_ff @(posedge axi_afu_if or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_free <= LM_CRED_W'(LM_RD_CREDITS);
            wr_free <= LM_CRED_W'(LM_WR_CREDITS);
        end
        else
        begin
            // A take and a return may land in the same cycle
            rd_free <= rd_free - rd_take + LM_CRED_W'(rd_line_done);
            wr_free <= wr_free - wr_take + LM_CRED_W'(wr_line_done);
        end
    end

    // Any legal request fits when a full burst worth of credits is free
    assign rd_ready = (rd_free >= LM_CRED_W'(LM_MAX_LINES));
    assign wr_ready = (wr_free >= LM_CRED_W'(LM_MAX_LINES));

endmodule

// File: hw/avmm_bridge/lm_axi_to_avmm.sv
/*
 * Chunk to Avalon-MM master bridge.
 * Buffers commands and write data, drives the Avalon master, tags read
 * beats with their request id and answers writes locally.
 */
`timescale 1ns/1ps

module lm_axi_to_avmm
    import lm_axi_pkg::*;
    import lm_avmm_pkg::*;
(
    input  logic                    axi_afu_if,
    input  logic                    arst_n,
    input  logic                    cmd_valid,
    input  avmm_cmd_t               cmd,
    input  logic                    wdata_valid,
    input  lm_wdata_t               wdata,
    output logic                    avm_read,
    output logic                    avm_write,
    output logic [LM_ADDR_W-1:0]    avm_address,
    output logic [AVMM_BURST_W-1:0] avm_burstcount,
    output logic [LM_DATA_W-1:0]    avm_writedata,
    output logic [LM_BE_W-1:0]      avm_byteenable,
    input  logic                    avm_waitrequest,
    input  logic                    avm_readdatavalid,
    input  logic [LM_DATA_W-1:0]    avm_readdata,
    output logic                    rsp_valid,
    output lm_rsp_t                 rsp,
    output logic                    b_valid,
    output lm_bresp_t               bresp,
    output logic                    rd_line_done,
    output logic                    wr_line_done
);

    // Command FIFO
    avmm_cmd_t            cq_mem [AVMM_CMD_DEPTH];
    logic [AVMM_CMD_AW:0] cq_wr_ptr;
    logic [AVMM_CMD_AW:0] cq_rd_ptr;
    logic                 cq_empty;
    logic                 cq_pop;
    avmm_cmd_t            cq_head;

    // Write data FIFO
    lm_wdata_t            wq_mem [LM_WR_CREDITS];
    logic [LM_WR_AW:0]    wq_wr_ptr;
    logic [LM_WR_AW:0]    wq_rd_ptr;
    logic                 wq_empty;
    lm_wdata_t            wq_head;

    // Read tag FIFO
    avmm_tag_t            tq_mem [LM_RD_CREDITS];
    logic [LM_RD_AW:0]    tq_wr_ptr;
    logic [LM_RD_AW:0]    tq_rd_ptr;
    avmm_tag_t            tq_head;

    logic [AVMM_BURST_W-1:0] wr_beat;
    logic [AVMM_BURST_W-1:0] rd_beat;
    logic                    rd_accept;
    logic                    wr_accept;
    logic                    wr_burst_end;
    logic                    rd_chunk_end;

    // ====================
    // Buffers
    // ====================
    assign cq_empty = (cq_wr_ptr == cq_rd_ptr);
    assign wq_empty = (wq_wr_ptr == wq_rd_ptr);
    assign cq_head  = cq_mem[cq_rd_ptr[AVMM_CMD_AW-1:0]];
    assign wq_head  = wq_mem[wq_rd_ptr[LM_WR_AW-1:0]];
    assign tq_head  = tq_mem[tq_rd_ptr[LM_RD_AW-1:0]];

    always_ff @(posedge axi_afu_if)
    begin
        if (cmd_valid)
            cq_mem[cq_wr_ptr[AVMM_CMD_AW-1:0]] <= cmd;
        if (wdata_valid)
            wq_mem[wq_wr_ptr[LM_WR_AW-1:0]] <= wdata;
        // A read is tagged when Avalon accepts it
        if (rd_accept)
            tq_mem[tq_wr_ptr[LM_RD_AW-1:0]] <= '{id: cq_head.id,
                                                 lines: cq_head.burstcount,
                                                 last: cq_head.last};
    end

    // ====================
    // Avalon master
    // ====================
    // The head chunk drives the bus directly and holds until popped,
    // so waitrequest leaves every field untouched
    assign avm_read       = ~cq_empty & ~cq_head.is_write;
    assign avm_write      = ~cq_empty &  cq_head.is_write & ~wq_empty;
    assign avm_address    = cq_head.addr;
    assign avm_burstcount = cq_head.burstcount;
    assign avm_writedata  = wq_head.data;
    assign avm_byteenable = wq_head.be;

    assign rd_accept    = avm_read  & ~avm_waitrequest;
    assign wr_accept    = avm_write & ~avm_waitrequest;
    // A write chunk leaves the FIFO with its final beat
    assign wr_burst_end = wr_accept & (wr_beat == cq_head.burstcount - 1'b1);
    assign cq_pop       = rd_accept | wr_burst_end;

    // Returning beats are matched against the oldest tag
    assign rd_chunk_end = avm_readdatavalid & (rd_beat == tq_head.lines - 1'b1);

    always_ff @(posedge axi_afu_if or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cq_wr_ptr <= '0;
            cq_rd_ptr <= '0;
            wq_wr_ptr <= '0;
            wq_rd_ptr <= '0;
            tq_wr_ptr <= '0;
            tq_rd_ptr <= '0;
            wr_beat   <= '0;
            rd_beat   <= '0;
            rsp_valid <= 1'b0;
            b_valid   <= 1'b0;
        end
        else
        begin
            if (cmd_valid)
                cq_wr_ptr <= cq_wr_ptr + 1'b1;
            if (cq_pop)
                cq_rd_ptr <= cq_rd_ptr + 1'b1;
            if (wdata_valid)
                wq_wr_ptr <= wq_wr_ptr + 1'b1;
            if (wr_accept)
                wq_rd_ptr <= wq_rd_ptr + 1'b1;
            if (rd_accept)
                tq_wr_ptr <= tq_wr_ptr + 1'b1;
            if (rd_chunk_end)
                tq_rd_ptr <= tq_rd_ptr + 1'b1;

            // Beat position inside the current write burst
            if (wr_burst_end)
                wr_beat <= '0;
            else if (wr_accept)
                wr_beat <= wr_beat + 1'b1;

            // Beat position inside the oldest outstanding read
            if (rd_chunk_end)
                rd_beat <= '0;
            else if (avm_readdatavalid)
                rd_beat <= rd_beat + 1'b1;

            rsp_valid <= avm_readdatavalid;
            // Writes are answered locally once the last chunk is accepted
            b_valid   <= wr_burst_end & cq_head.last;
        end
    end

    // ====================
    // Responses
    // ====================
    always_ff @(posedge axi_afu_if)
    begin
        rsp.id   <= tq_head.id;
        rsp.data <= avm_readdata;
        rsp.last <= rd_chunk_end & tq_head.last;
        bresp.id <= cq_head.id;
    end

    // Credit returns toward the tracker
    assign rd_line_done = rsp_valid;
    assign wr_line_done = wr_accept;

endmodule

// File: hw/lm_local_mem_as_axi.sv
/*
 * Local memory exported to the accelerator as a burst request port.
 * Chains the burst mapper and the Avalon bridge, with the credit
 * tracker standing in for back-pressure on the accelerator side.
 */
`timescale 1ns/1ps

module lm_local_mem_as_axi
    import lm_axi_pkg::*;
    import lm_avmm_pkg::*;
(
    input  logic                    axi_afu_if,
    input  logic                    arst_n,
    // Accelerator side
    input  logic                    req_valid,
    input  lm_req_t                 req,
    input  logic                    wdata_valid,
    input  lm_wdata_t               wdata,
    output logic                    rd_ready,
    output logic                    wr_ready,
    output logic                    rsp_valid,
    output lm_rsp_t                 rsp,
    output logic                    b_valid,
    output lm_bresp_t               bresp,
    // Avalon memory side
    output logic                    avm_read,
    output logic                    avm_write,
    output logic [LM_ADDR_W-1:0]    avm_address,
    output logic [AVMM_BURST_W-1:0] avm_burstcount,
    output logic [LM_DATA_W-1:0]    avm_writedata,
    output logic [LM_BE_W-1:0]      avm_byteenable,
    input  logic                    avm_waitrequest,
    input  logic                    avm_readdatavalid,
    input  logic [LM_DATA_W-1:0]    avm_readdata
);

    logic      cmd_valid;
    avmm_cmd_t cmd;
    logic      rd_line_done;
    logic      wr_line_done;

    // Requests become Avalon-sized chunks
    lm_burst_mapper u_burst_mapper (
        .axi_afu_if (axi_afu_if),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req        (req),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd)
    );

    // Each request claims its full line count at the strobe
    lm_rsp_credits u_rsp_credits (
        .axi_afu_if   (axi_afu_if),
        .arst_n       (arst_n),
        .take_valid   (req_valid),
        .take_write   (req.is_write),
        .take_lines   (LM_CNT_W'(req.len) + 1'b1),
        .rd_line_done (rd_line_done),
        .wr_line_done (wr_line_done),
        .rd_ready     (rd_ready),
        .wr_ready     (wr_ready)
    );

    lm_axi_to_avmm u_axi_to_avmm (
        .axi_afu_if        (axi_afu_if),
        .arst_n            (arst_n),
        .cmd_valid         (cmd_valid),
        .cmd               (cmd),
        .wdata_valid       (wdata_valid),
        .wdata             (wdata),
        .avm_read          (avm_read),
        .avm_write         (avm_write),
        .avm_address       (avm_address),
        .avm_burstcount    (avm_burstcount),
        .avm_writedata     (avm_writedata),
        .avm_byteenable    (avm_byteenable),
        .avm_waitrequest   (avm_waitrequest),
        .avm_readdatavalid (avm_readdatavalid),
        .avm_readdata      (avm_readdata),
        .rsp_valid         (rsp_valid),
        .rsp               (rsp),
        .b_valid           (b_valid),
        .bresp             (bresp),
        .rd_line_done      (rd_line_done),
        .wr_line_done      (wr_line_done)
    );

endmodule

// File: verif/lm_local_mem_assert.sv
/*
 * Bound checks on the Avalon master and the read response stream.
 */
`timescale 1ns/1ps

module lm_local_mem_assert
    import lm_axi_pkg::*;
    import lm_avmm_pkg::*;
(
    input logic                    axi_afu_if,
    input logic                    arst_n,
    input logic                    avm_read,
    input logic                    avm_write,
    input logic                    avm_waitrequest,
    input logic [LM_ADDR_W-1:0]    avm_address,
    input logic [AVMM_BURST_W-1:0] avm_burstcount,
    input logic                    rsp_valid
);

    // Read lines accepted by Avalon and not yet answered
    int rd_pending;

    always_ff @(posedge axi_afu_if or negedge arst_n)
    begin
        if (!arst_n)
            rd_pending <= 0;
        else
            rd_pending <= rd_pending
                        + ((avm_read && !avm_waitrequest) ? int'(avm_burstcount) : 0)
                        - (rsp_valid ? 1 : 0);
    end

    cmd_held: assert property (@(posedge axi_afu_if) disable iff (!arst_n)
        (avm_read || avm_write) && avm_waitrequest |=>
        $stable(avm_read) && $stable(avm_write) &&
        $stable(avm_address) && $stable(avm_burstcount))
        else $error("Avalon command changed under waitrequest");

    burst_range: assert property (@(posedge axi_afu_if) disable iff (!arst_n)
        (avm_read || avm_write) |->
        (avm_burstcount >= 1) && (avm_burstcount <= AVMM_MAX_BURST))
        else $error("avm_burstcount out of range");

    rsp_has_read: assert property (@(posedge axi_afu_if) disable iff (!arst_n)
        rsp_valid |-> rd_pending > 0)
        else $error("read response with no read outstanding");

endmodule

bind lm_local_mem_as_axi lm_local_mem_assert u_assert (
    .axi_afu_if      (axi_afu_if),
    .arst_n          (arst_n),
    .avm_read        (avm_read),
    .avm_write       (avm_write),
    .avm_waitrequest (avm_waitrequest),
    .avm_address     (avm_address),
    .avm_burstcount  (avm_burstcount),
    .rsp_valid       (rsp_valid)
);

// File: verif/tb_lm_local_mem.sv
/*
 * Testbench for the local memory bridge.
 * Drives random read and write bursts, models the Avalon memory and
 * checks responses, chunking and credits against a shadow model.
 */
`timescale 1ns/1ps

module tb_lm_local_mem
    import lm_axi_pkg::*;
    import lm_avmm_pkg::*;
();

    localparam int CLK_NS      = 8;
    localparam int NUM_RAND    = 360;
    localparam int WATCHDOG_NS = 400 * 200 * CLK_NS;

    logic                    axi_afu_if;
    logic                    arst_n;
    logic                    req_valid;
    lm_req_t                 req;
    logic                    wdata_valid;
    lm_wdata_t               wdata;
    logic                    rd_ready;
    logic                    wr_ready;
    logic                    rsp_valid;
    lm_rsp_t                 rsp;
    logic                    b_valid;
    lm_bresp_t               bresp;
    logic                    avm_read;
    logic                    avm_write;
    logic [LM_ADDR_W-1:0]    avm_address;
    logic [AVMM_BURST_W-1:0] avm_burstcount;
    logic [LM_DATA_W-1:0]    avm_writedata;
    logic [LM_BE_W-1:0]      avm_byteenable;
    logic                    avm_waitrequest;
    logic                    avm_readdatavalid;
    logic [LM_DATA_W-1:0]    avm_readdata;

    // Memory model contents and the shadow copy seen by the reference
    logic [LM_DATA_W-1:0] mem [int];
    logic [LM_DATA_W-1:0] shadow [int];

    // Expected traffic in issue order
    lm_rsp_t              exp_rsp_q [$];
    logic [LM_ID_W-1:0]   exp_b_q [$];
    avmm_cmd_t            exp_chunk_q [$];

    // Read beats waiting to be returned by the memory model
    logic [LM_DATA_W-1:0] ret_data_q [$];
    int                   ret_due_q [$];
    int                   last_due;
    int                   due_min;
    int                   cycle;
    int                   wr_left;
    int                   wr_addr;
    logic                 stall;
    int                   mismatch_cnt;
    int                   other_cnt;
    int                   seed_val;

    lm_local_mem_as_axi dut (.*);

    always #(CLK_NS / 2) axi_afu_if = ~axi_afu_if;

    // ====================
    // Helpers
    // ====================
    // Untouched lines read back as a pattern of their own address
    function automatic logic [LM_DATA_W-1:0] fill_line(input int a);
        logic [LM_ADDR_W-1:0] aa;
        aa = LM_ADDR_W'(a);
        return {aa ^ 26'h1555555, 6'h2a, aa, 6'h13};
    endfunction

    function automatic logic [LM_DATA_W-1:0] mem_line(input int a);
        return mem.exists(a) ? mem[a] : fill_line(a);
    endfunction

    function automatic logic [LM_DATA_W-1:0] shadow_line(input int a);
        return shadow.exists(a) ? shadow[a] : fill_line(a);
    endfunction

    // Merge a new line into an old one under its byte enables
    function automatic logic [LM_DATA_W-1:0] merge_be(input logic [LM_DATA_W-1:0] old_d,
                                                      input logic [LM_DATA_W-1:0] new_d,
                                                      input logic [LM_BE_W-1:0]   be);
        logic [LM_DATA_W-1:0] res;
        res = old_d;
        for (int b = 0; b < LM_BE_W; b++)
            if (be[b])
                res[b*8 +: 8] = new_d[b*8 +: 8];
        return res;
    endfunction

    task automatic report_mismatch(input string name, input logic [LM_DATA_W-1:0] got,
                                   input logic [LM_DATA_W-1:0] exp);
        $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        mismatch_cnt++;
    endtask

    task automatic report_error(input string what);
        $display("error at %0t: %s", $time, what);
        other_cnt++;
    endtask

    // Compare one accepted Avalon command against the next expected chunk
    task automatic check_chunk(input logic is_wr);
        avmm_cmd_t c;
        if (exp_chunk_q.size() == 0)
        begin
            report_error("Avalon command accepted with no chunk expected");
            return;
        end
        c = exp_chunk_q.pop_front();
        if (c.is_write != is_wr)
            report_mismatch("avm_write", is_wr, c.is_write);
        if (c.addr != avm_address)
            report_mismatch("avm_address", avm_address, c.addr);
        if (c.burstcount != avm_burstcount)
            report_mismatch("avm_burstcount", avm_burstcount, c.burstcount);
    endtask

    // ====================
    // Avalon memory model
    // ====================
    // Bus state is sampled mid-cycle, where every DUT output is settled
    always @(negedge axi_afu_if)
    begin
        if (arst_n)
        begin
            if (avm_read && !avm_waitrequest)
            begin
                check_chunk(1'b0);
                for (int i = 0; i < int'(avm_burstcount); i++)
                begin
                    // Beats follow each other and never come back sooner than the delay
                    due_min  = cycle + 1 + $urandom_range(0, 4);
                    last_due = (last_due + 1 > due_min) ? last_due + 1 : due_min;
                    ret_data_q.push_back(mem_line(int'(avm_address) + i));
                    ret_due_q.push_back(last_due);
                end
            end
            if (avm_write && !avm_waitrequest)
            begin
                if (wr_left == 0)
                begin
                    check_chunk(1'b1);
                    wr_addr = int'(avm_address);
                    wr_left = int'(avm_burstcount);
                end
                mem[wr_addr] = merge_be(mem_line(wr_addr), avm_writedata, avm_byteenable);
                wr_addr++;
                wr_left--;
            end
            if (rsp_valid)
            begin
                if (exp_rsp_q.size() == 0)
                    report_error("read response with no read outstanding");
                else
                begin
                    lm_rsp_t e;
                    e = exp_rsp_q.pop_front();
                    if (rsp.id != e.id)
                        report_mismatch("rsp.id", rsp.id, e.id);
                    if (rsp.data != e.data)
                        report_mismatch("rsp.data", rsp.data, e.data);
                    if (rsp.last != e.last)
                        report_mismatch("rsp.last", rsp.last, e.last);
                end
            end
            if (b_valid)
            begin
                if (exp_b_q.size() == 0)
                    report_error("write response with no write outstanding");
                else if (bresp.id != exp_b_q[0])
                    report_mismatch("bresp.id", bresp.id, exp_b_q.pop_front());
                else
                    void'(exp_b_q.pop_front());
            end
        end
    end

    // Memory outputs change 1 ns after the edge
    always @(posedge axi_afu_if)
    begin
        cycle++;
        #1;
        if (!arst_n)
        begin
            avm_waitrequest   = 1'b0;
            avm_readdatavalid = 1'b0;
        end
        else
        begin
            avm_waitrequest = stall | ($urandom_range(0, 3) == 0);
            if (ret_due_q.size() != 0 && ret_due_q[0] <= cycle)
            begin
                avm_readdatavalid = 1'b1;
                avm_readdata      = ret_data_q.pop_front();
                void'(ret_due_q.pop_front());
            end
            else
                avm_readdatavalid = 1'b0;
        end
    end

    // ====================
    // Stimulus
    // ====================
    // Issue one request and its write lines, and record what must come back
    task automatic issue_req(input logic is_wr, input int id, input int addr, input int len);
        lm_wdata_t lines [LM_MAX_LINES];
        lm_rsp_t   e;
        avmm_cmd_t c;
        int        left;
        while (!(is_wr ? wr_ready : rd_ready))
        begin
            @(posedge axi_afu_if);
            #1;
        end
        left = len + 1;
        c    = '0;
        while (left > 0)
        begin
            c.is_write   = is_wr;
            c.addr       = LM_ADDR_W'(addr + len + 1 - left);
            c.burstcount = AVMM_BURST_W'((left > AVMM_MAX_BURST) ? AVMM_MAX_BURST : left);
            exp_chunk_q.push_back(c);
            left -= int'(c.burstcount);
        end
        for (int i = 0; i <= len; i++)
        begin
            if (is_wr)
            begin
                lines[i].data = {$urandom(), $urandom()};
                lines[i].be   = LM_BE_W'($urandom());
                shadow[addr + i] = merge_be(shadow_line(addr + i), lines[i].data, lines[i].be);
            end
            else
            begin
                e.id   = LM_ID_W'(id);
                e.data = shadow_line(addr + i);
                e.last = (i == len);
                exp_rsp_q.push_back(e);
            end
        end
        if (is_wr)
            exp_b_q.push_back(LM_ID_W'(id));
        req_valid    = 1'b1;
        req.is_write = is_wr;
        req.id       = LM_ID_W'(id);
        req.addr     = LM_ADDR_W'(addr);
        req.len      = LM_LEN_W'(len);
        for (int i = 0; i <= (is_wr ? len : 0); i++)
        begin
            wdata_valid = is_wr;
            wdata       = lines[i];
            @(posedge axi_afu_if);
            #1;
            req_valid   = 1'b0;
            wdata_valid = 1'b0;
        end
    endtask

    // Wait until every expected response and chunk has been seen
    task automatic wait_idle();
        int n;
        n = 0;
        while ((exp_rsp_q.size() + exp_b_q.size() + exp_chunk_q.size() != 0) && n < 4000)
        begin
            @(posedge axi_afu_if);
            #1;
            n++;
        end
        if (n >= 4000)
            report_error("responses still pending after the drain limit");
        repeat (4) @(posedge axi_afu_if);
        #1;
    endtask

    // Ends a run that stops making progress
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        seed_val          = $urandom(25);
        axi_afu_if        = 1'b0;
        arst_n            = 1'b0;
        req_valid         = 1'b0;
        req               = '0;
        wdata_valid       = 1'b0;
        wdata             = '0;
        avm_waitrequest   = 1'b0;
        avm_readdatavalid = 1'b0;
        avm_readdata      = '0;
        stall             = 1'b0;
        cycle             = 0;
        last_due          = 0;
        due_min           = 0;
        wr_left           = 0;
        mismatch_cnt      = 0;
        other_cnt         = 0;

        // Reset values of the outputs
        repeat (3) @(posedge axi_afu_if);
        #1;
        arst_n = 1'b1;
        if (avm_read || avm_write || rsp_valid || b_valid)
            report_error("Avalon command or response active right after reset");
        @(posedge axi_afu_if);
        #1;
        if (!rd_ready || !wr_ready)
            report_error("ready levels not high one cycle after reset");

        // Write a full burst, then read it back with byte enables applied
        issue_req(1'b1, 3, 40, 15);
        issue_req(1'b0, 5, 40, 15);
        issue_req(1'b0, 6, 38, 6);
        wait_idle();

        // Stalled memory keeps rd_ready up for a full burst of headroom
        // and drops it once a single line more is outstanding
        stall = 1'b1;
        repeat (2) @(posedge axi_afu_if);
        #1;
        issue_req(1'b0, 1, 100, LM_RD_CREDITS - LM_MAX_LINES - 1);
        if (!rd_ready)
            report_error("rd_ready fell with only a full burst of read lines outstanding");
        issue_req(1'b0, 2, 100 + LM_RD_CREDITS - LM_MAX_LINES, 0);
        if (rd_ready)
            report_error("rd_ready stayed high with one line past the credit limit outstanding");
        repeat (50) @(posedge axi_afu_if);
        #1;
        if (rd_ready)
            report_error("rd_ready rose while the memory was stalled");
        stall = 1'b0;
        wait_idle();
        if (!rd_ready)
            report_error("rd_ready stayed low after the reads drained");

        // Random traffic
        for (int k = 0; k < NUM_RAND; k++)
        begin
            issue_req($urandom_range(0, 1), $urandom_range(0, 15),
                      $urandom_range(0, 255), $urandom_range(0, 15));
            repeat ($urandom_range(0, 2)) @(posedge axi_afu_if);
            #1;
        end
        wait_idle();

        $display("closing counts: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
        if (mismatch_cnt + other_cnt == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: compile.f
common/lm_axi_pkg.sv
common/lm_avmm_pkg.sv
hw/burst_map/lm_burst_mapper.sv
hw/rsp_credits/lm_rsp_credits.sv
hw/avmm_bridge/lm_axi_to_avmm.sv
hw/lm_local_mem_as_axi.sv
verif/lm_local_mem_assert.sv
verif/tb_lm_local_mem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the local memory bridge testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module tb_lm_local_mem -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0
